//--- cpu_top.f
verilog/cpu_pkg.sv
verilog/fetch_unit.sv
verilog/exec_unit.sv
verilog/mem_arbiter.sv
verilog/page_mmu.sv
verilog/cpu_top.sv
tb/cpu_top_sva.sv
tb/tb_cpu_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_cpu_top \
       -f cpu_top.f -o tb_cpu_top \
  && ./obj_dir/tb_cpu_top \
  || { echo "simulation failed"; exit 1; }

//--- tb/cpu_top_sva.sv
`timescale 1ns/1ns

module cpu_top_sva (
  input logic clka,
  input logic rst,
  input logic mem_en,
  input logic mem_we,
  input logic halted
);

  // a write is always a bus access
  a_we_has_en: assert property (@(posedge clka) disable iff (!rst) mem_we |-> mem_en)
    else $error("mem_we high without mem_en");

  a_quiet_halt: assert property (@(posedge clka) disable iff (!rst) halted |-> !mem_en)
    else $error("bus access while halted");

  // only reset clears halted
  a_halt_sticky: assert property (@(posedge clka) disable iff (!rst) halted |=> halted)
    else $error("halted fell without reset");

endmodule

bind cpu_top cpu_top_sva i_cpu_top_sva (.*);

//--- tb/tb_cpu_top.sv
`timescale 1ns/1ns

module tb_cpu_top;

  localparam int NUM_REGS = 8;
  localparam int NUM_PAGES = 14;
  localparam int PW = cpu_pkg::PAGE_WORDS;
  localparam int MAX_INSTR = 34;
  localparam int TIMEOUT = 12000;   // 4 runs x 34 instr x 3 accesses x 30 cycles, rounded

  logic           clka;
  logic           rst;
  logic           mem_en;
  logic           mem_we;
  cpu_pkg::addr_t mem_addr;
  cpu_pkg::word_t mem_wdata;
  cpu_pkg::word_t mem_rdata = '0;
  logic           halted;

  cpu_pkg::word_t mem [1024];     // external memory model
  int             prog_len;       // next free code word
  int             ref_next [NUM_PAGES];
  int             ref_log [NUM_PAGES];
  int             exp_addr [$];
  cpu_pkg::word_t exp_data [$];
  int             n_writes = 0;
  int             cycles = 0;
  logic [7:0]     rand_ops [7] = '{cpu_pkg::OP_NUM2REG, cpu_pkg::OP_REG_PLUS,
                                   cpu_pkg::OP_REG_MINUS, cpu_pkg::OP_RAM2REG,
                                   cpu_pkg::OP_REG2RAM, cpu_pkg::OP_JMP, 8'h09};

  cpu_top #(.NUM_REGS(NUM_REGS), .NUM_PAGES(NUM_PAGES)) i_cpu_top (
    .clka(clka), .rst(rst), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .halted(halted)
  );

  initial begin
    clka = 1'b0;
    forever #4 clka = ~clka;
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // walk the chain from page 0, append the first free page on a miss
  function automatic int translate(input int addr);
    int lp;
    int pp;
    int fr;
    lp = addr / PW;
    pp = 0;
    if (lp != 0) begin
      pp = ref_next[0];
      while (ref_log[pp] != lp && ref_next[pp] != pp) pp = ref_next[pp];
      if (ref_log[pp] != lp) begin
        fr = 1;
        while (ref_log[fr] != 0) fr++;
        ref_next[pp] = fr;
        ref_next[fr] = fr;
        ref_log[fr] = lp;
        pp = fr;
      end
    end
    return pp * PW + addr % PW;
  endfunction

  // executes the program in mem, returns the number of expected writes
  function automatic int ref_run();
    cpu_pkg::word_t rmem [1024];
    cpu_pkg::word_t r [NUM_REGS];
    cpu_pkg::word_t opd;
    logic [7:0]     op;
    int             pc;
    int             rn;
    int             pa;
    rmem = mem;
    for (int i = 0; i < NUM_REGS; i++) r[i] = '0;
    for (int i = 0; i < NUM_PAGES; i++) begin
      ref_next[i] = i;
      ref_log[i] = 0;
    end
    ref_next[0] = 5;    // boot chain 0, 5, 2, 1
    ref_next[5] = 2;
    ref_next[2] = 1;
    ref_log[5] = 2;
    ref_log[2] = 3;
    ref_log[1] = 1;
    exp_addr.delete();
    exp_data.delete();
    pc = 0;
    for (int steps = 0; steps < 4 * MAX_INSTR; steps++) begin
      op = rmem[pc][15:8];
      rn = int'(rmem[pc][7:0]) % NUM_REGS;
      opd = rmem[pc + 1];
      pc = pc + 2;
      case (op)
        cpu_pkg::OP_NUM2REG:   r[rn] = opd;
        cpu_pkg::OP_REG_PLUS:  r[rn] = r[rn] + opd;
        cpu_pkg::OP_REG_MINUS: r[rn] = r[rn] - opd;
        cpu_pkg::OP_RAM2REG:   r[rn] = rmem[translate(int'(opd[9:0]))];
        cpu_pkg::OP_REG2RAM: begin
          pa = translate(int'(opd[9:0]));
          rmem[pa] = r[rn];
          exp_addr.push_back(pa);
          exp_data.push_back(r[rn]);
        end
        cpu_pkg::OP_JMP:       pc = int'(opd[9:0]);
        cpu_pkg::OP_EXIT:      return exp_addr.size();
        default: ;
      endcase
    end
    return -1;    // program never reached exit
  endfunction

  // memory answers one cycle after the strobe
  always @(negedge clka) begin
    if (mem_en) begin
      mem_rdata = mem[mem_addr];
      if (mem_we) mem[mem_addr] = mem_wdata;
    end
  end

  always @(negedge clka) begin
    if (!rst) begin
      n_writes <= 0;
    end else if (mem_en && mem_we) begin
      check("write within expected list", 32'(n_writes < exp_addr.size()), 32'd1);
      check("write address", 32'(mem_addr), 32'(exp_addr[n_writes]));
      check("write data", 32'(mem_wdata), 32'(exp_data[n_writes]));
      n_writes <= n_writes + 1;
    end
  end

  always @(posedge clka) begin
    if (cycles == TIMEOUT) begin
      $display("timeout: the processor did not halt within %0d cycles", TIMEOUT);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end else begin
      cycles <= cycles + 1;
    end
  end

  task automatic put(input logic [7:0] op, input int rnum, input int operand);
    mem[prog_len] = {op, 8'(rnum)};
    mem[prog_len + 1] = 16'(operand);
    prog_len += 2;
  endtask

  // hold reset and refill memory with an address pattern
  task automatic start_run();
    @(negedge clka);
    rst = 1'b0;
    for (int i = 0; i < 1024; i++) mem[i] = 16'(i * 40503) ^ 16'h5a5a;
    prog_len = 0;
  endtask

  task automatic finish_run();
    int n_exp;
    n_exp = ref_run();
    repeat (2) @(negedge clka);
    rst = 1'b1;
    while (!halted) @(negedge clka);
    repeat (10) @(negedge clka);    // any late write would show here
    check("write count", 32'(n_writes), 32'(n_exp));
  endtask

  task automatic build_random();
    int page;
    int tgt;
    logic [7:0] op;
    for (int i = 0; i < MAX_INSTR - 1; i++) begin
      op = rand_ops[$urandom_range(6, 0)];
      page = int'($urandom_range(3, 0));
      if (op == cpu_pkg::OP_JMP) begin
        tgt = i + 1 + int'($urandom_range(2, 0));   // forward only
        if (tgt > MAX_INSTR - 1) tgt = MAX_INSTR - 1;
        put(op, 0, 2 * tgt);
      end else if (op == cpu_pkg::OP_RAM2REG || op == cpu_pkg::OP_REG2RAM) begin
        if (page == 0) put(op, int'($urandom_range(255, 0)), 68 + int'($urandom_range(3, 0)));
        else put(op, int'($urandom_range(255, 0)), page * PW + int'($urandom_range(71, 0)));
      end else begin
        put(op, int'($urandom_range(255, 0)), int'($urandom_range(65535, 0)));
      end
    end
    put(cpu_pkg::OP_EXIT, 0, 0);
  endtask

  initial begin
    rst = 1'b0;
    void'($urandom(32'hc789_311a));
    // arithmetic with wraparound, jmp over a store, store after exit
    start_run();
    put(cpu_pkg::OP_NUM2REG, 1, 16'hfff0);
    put(cpu_pkg::OP_REG_PLUS, 9, 16'h0025);
    put(cpu_pkg::OP_REG2RAM, 1, 68);
    put(cpu_pkg::OP_NUM2REG, 2, 16'h0003);
    put(cpu_pkg::OP_REG_MINUS, 2, 16'h0010);
    put(cpu_pkg::OP_REG2RAM, 2, 69);
    put(cpu_pkg::OP_JMP, 0, 16);
    put(cpu_pkg::OP_REG2RAM, 1, 70);
    put(cpu_pkg::OP_EXIT, 0, 0);
    put(cpu_pkg::OP_REG2RAM, 2, 71);
    finish_run();
    // mapped pages of the boot chain
    start_run();
    mem[2 * PW + 10] = 16'h5eed;
    put(cpu_pkg::OP_NUM2REG, 3, 16'h1234);
    put(cpu_pkg::OP_REG2RAM, 3, 2 * PW + 5);
    put(cpu_pkg::OP_NUM2REG, 4, 16'habcd);
    put(cpu_pkg::OP_REG2RAM, 4, PW + 7);
    put(cpu_pkg::OP_RAM2REG, 5, 3 * PW + 10);
    put(cpu_pkg::OP_REG2RAM, 5, 70);
    put(cpu_pkg::OP_EXIT, 0, 0);
    finish_run();
    // unmapped pages get free pages 3 and 4
    start_run();
    put(cpu_pkg::OP_NUM2REG, 0, 16'h0404);
    put(cpu_pkg::OP_REG2RAM, 0, 4 * PW + 1);
    put(cpu_pkg::OP_NUM2REG, 6, 16'h0606);
    put(cpu_pkg::OP_REG2RAM, 6, 6 * PW + 2);
    put(cpu_pkg::OP_REG2RAM, 0, 4 * PW + 3);
    put(cpu_pkg::OP_EXIT, 0, 0);
    finish_run();
    start_run();
    build_random();
    finish_run();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- verilog/cpu_pkg.sv
package cpu_pkg;

  localparam int ADDR_W = 10;       // logical and physical word address
  localparam int DATA_W = 16;
  localparam int PAGE_WORDS = 72;   // words per mmu page

  // opcodes, first word bits [15:8]
  localparam logic [7:0] OP_JMP       = 8'd1;
  localparam logic [7:0] OP_RAM2REG   = 8'd2;
  localparam logic [7:0] OP_REG2RAM   = 8'd3;
  localparam logic [7:0] OP_NUM2REG   = 8'd4;
  localparam logic [7:0] OP_REG_PLUS  = 8'd5;
  localparam logic [7:0] OP_REG_MINUS = 8'd6;
  localparam logic [7:0] OP_EXIT      = 8'd17;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;

  // request from a requester, held until ack
  typedef struct packed {
    logic  we;
    addr_t addr;    // logical address
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  ack;     // one-cycle strobe
    word_t rdata;
  } mem_resp_t;

  // two-word instruction, op and rnum from the first word
  typedef struct packed {
    logic [7:0] op;
    logic [7:0] rnum;
    word_t      operand;
  } instr_t;

endpackage

//--- verilog/cpu_top.sv
`timescale 1ns/1ns

module cpu_top #(
  parameter int NUM_REGS  = 8,
  parameter int NUM_PAGES = 14
) (
  input  logic           clka,
  input  logic           rst,
  output logic           mem_en,
  output logic           mem_we,
  output cpu_pkg::addr_t mem_addr,
  output cpu_pkg::word_t mem_wdata,
  input  cpu_pkg::word_t mem_rdata,
  output logic           halted
);

  logic               f_req, e_req, m_start, m_done;
  cpu_pkg::mem_req_t  f_pkt, e_pkt, m_pkt;
  cpu_pkg::mem_resp_t f_resp, e_resp;
  cpu_pkg::word_t     m_rdata;
  cpu_pkg::instr_t    instr;
  logic               instr_valid, instr_taken, redirect;
  cpu_pkg::addr_t     redirect_pc;

  fetch_unit i_fetch_unit (
    .clka(clka), .rst(rst), .req(f_req), .req_pkt(f_pkt), .resp(f_resp),
    .instr(instr), .instr_valid(instr_valid), .instr_taken(instr_taken),
    .redirect(redirect), .redirect_pc(redirect_pc), .halt(halted)
  );

  exec_unit #(.NUM_REGS(NUM_REGS)) i_exec_unit (
    .clka(clka), .rst(rst), .instr(instr), .instr_valid(instr_valid),
    .instr_taken(instr_taken), .redirect(redirect), .redirect_pc(redirect_pc),
    .req(e_req), .req_pkt(e_pkt), .resp(e_resp), .halted(halted)
  );

  mem_arbiter i_mem_arbiter (
    .clka(clka), .rst(rst), .f_req(f_req), .f_pkt(f_pkt), .f_resp(f_resp),
    .e_req(e_req), .e_pkt(e_pkt), .e_resp(e_resp), .m_start(m_start),
    .m_pkt(m_pkt), .m_done(m_done), .m_rdata(m_rdata)
  );

  page_mmu #(.NUM_PAGES(NUM_PAGES)) i_page_mmu (
    .clka(clka), .rst(rst), .start(m_start), .pkt(m_pkt), .done(m_done),
    .rdata(m_rdata), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

endmodule

//--- verilog/exec_unit.sv
`timescale 1ns/1ns

module exec_unit #(
  parameter int NUM_REGS = 8
) (
  input  logic                clka,
  input  logic                rst,
  input  cpu_pkg::instr_t     instr,
  input  logic                instr_valid,
  output logic                instr_taken,
  output logic                redirect,
  output cpu_pkg::addr_t      redirect_pc,
  output logic                req,
  output cpu_pkg::mem_req_t   req_pkt,
  input  cpu_pkg::mem_resp_t  resp,
  output logic                halted
);

  localparam int RW = $clog2(NUM_REGS);

  cpu_pkg::word_t regs [NUM_REGS];
  logic [RW-1:0]  ridx;     // register of the current instruction
  logic [RW-1:0]  ld_idx;   // destination of a pending load
  logic           take;
  logic           is_mem;

  assign ridx = RW'(instr.rnum % NUM_REGS);

  // busy while a load or store is outstanding
  assign take        = instr_valid && !req && !halted;
  assign instr_taken = take;

  assign redirect    = take && (instr.op == cpu_pkg::OP_JMP);
  assign redirect_pc = instr.operand[cpu_pkg::ADDR_W-1:0];

  assign is_mem = (instr.op == cpu_pkg::OP_RAM2REG) || (instr.op == cpu_pkg::OP_REG2RAM);

  always_ff @(posedge clka) begin
    if (!rst) begin
      req    <= 1'b0;
      halted <= 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (req && resp.ack) begin
        req <= 1'b0;
        if (!req_pkt.we) begin
          regs[ld_idx] <= resp.rdata;   // ram2reg completes here
        end
      end
      if (take) begin
        case (instr.op)
          cpu_pkg::OP_NUM2REG:   regs[ridx] <= instr.operand;
          cpu_pkg::OP_REG_PLUS:  regs[ridx] <= regs[ridx] + instr.operand;
          cpu_pkg::OP_REG_MINUS: regs[ridx] <= regs[ridx] - instr.operand;
          cpu_pkg::OP_RAM2REG,
          cpu_pkg::OP_REG2RAM:   req <= 1'b1;
          cpu_pkg::OP_EXIT:      halted <= 1'b1;  // sticky until reset
          default: ;                              // jmp via redirect, rest ignored
        endcase
      end
    end
  end

  // request payload, latched with the instruction
  always_ff @(posedge clka) begin
    if (take && is_mem) begin
      req_pkt.we    <= (instr.op == cpu_pkg::OP_REG2RAM);
      req_pkt.addr  <= instr.operand[cpu_pkg::ADDR_W-1:0];
      req_pkt.wdata <= regs[ridx];
      ld_idx        <= ridx;
    end
  end

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
  input  logic                clka,
  input  logic                rst,
  output logic                req,
  output cpu_pkg::mem_req_t   req_pkt,
  input  cpu_pkg::mem_resp_t  resp,
  output cpu_pkg::instr_t     instr,
  output logic                instr_valid,
  input  logic                instr_taken,
  input  logic                redirect,
  input  cpu_pkg::addr_t      redirect_pc,
  input  logic                halt
);

  typedef enum logic [1:0] {S_W1, S_W2, S_FULL} state_e;

  state_e         state;
  cpu_pkg::addr_t pc;     // address of the next word to fetch

  assign req         = (state != S_FULL) && !halt;
  assign req_pkt     = '{we: 1'b0, addr: pc, wdata: '0};
  assign instr_valid = (state == S_FULL);

  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= S_W1;
      pc    <= '0;
    end else if (redirect) begin
      pc    <= redirect_pc;   // only while full, so no read is in flight
      state <= S_W1;
    end else if (resp.ack) begin
      if (state == S_W1) begin
        instr.op   <= resp.rdata[15:8];
        instr.rnum <= resp.rdata[7:0];
        pc         <= pc + 1'b1;
        state      <= S_W2;
      end else begin
        instr.operand <= resp.rdata;
        pc            <= pc + 1'b1;
        state         <= S_FULL;
      end
    end else if (state == S_FULL && instr_taken) begin
      state <= S_W1;    // prefetch next one right away
    end
  end

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                clka,
  input  logic                rst,
  input  logic                f_req,
  input  cpu_pkg::mem_req_t   f_pkt,
  output cpu_pkg::mem_resp_t  f_resp,
  input  logic                e_req,
  input  cpu_pkg::mem_req_t   e_pkt,
  output cpu_pkg::mem_resp_t  e_resp,
  output logic                m_start,
  output cpu_pkg::mem_req_t   m_pkt,
  input  logic                m_done,
  input  cpu_pkg::word_t      m_rdata
);

  logic busy;
  logic owner_exec;   // 1 when the execute unit holds the bus

  assign f_resp = '{ack: m_done && !owner_exec, rdata: m_rdata};
  assign e_resp = '{ack: m_done && owner_exec, rdata: m_rdata};

  always_ff @(posedge clka) begin
    if (!rst) begin
      busy       <= 1'b0;
      m_start    <= 1'b0;
      owner_exec <= 1'b0;
    end else begin
      m_start <= 1'b0;
      if (busy) begin
        if (m_done) busy <= 1'b0;
      end else if (e_req || f_req) begin
        busy       <= 1'b1;
        m_start    <= 1'b1;
        owner_exec <= e_req;   // execute unit first
      end
    end
  end

  always_ff @(posedge clka) begin
    if (!busy && (e_req || f_req)) m_pkt <= e_req ? e_pkt : f_pkt;
  end

endmodule

//--- verilog/page_mmu.sv
`timescale 1ns/1ns

module page_mmu #(
  parameter int NUM_PAGES = 14
) (
  input  logic               clka,
  input  logic               rst,
  input  logic               start,
  input  cpu_pkg::mem_req_t  pkt,
  output logic               done,
  output cpu_pkg::word_t     rdata,
  output logic               mem_en,
  output logic               mem_we,
  output cpu_pkg::addr_t     mem_addr,
  output cpu_pkg::word_t     mem_wdata,
  input  cpu_pkg::word_t     mem_rdata
);

  localparam int PH_W  = $clog2(NUM_PAGES);
  localparam int PG_W  = $clog2((1 << cpu_pkg::ADDR_W) / cpu_pkg::PAGE_WORDS + 1);
  localparam int OFF_W = $clog2(cpu_pkg::PAGE_WORDS);

  typedef enum logic [1:0] {S_IDLE, S_WALK, S_SCAN} state_e;

  state_e            state;
  logic [PH_W-1:0]   next_pg [NUM_PAGES];   // chain links, self link marks last
  logic [PG_W-1:0]   log_pg  [NUM_PAGES];   // logical page owned, 0 is free
  logic [PG_W-1:0]   last_lp;
  logic [PH_W-1:0]   last_pp;
  logic [PH_W-1:0]   cur;
  logic [PH_W-1:0]   scan;
  cpu_pkg::mem_req_t pkt_q;
  cpu_pkg::mem_req_t req_now;
  logic [PG_W-1:0]   lp_now;
  logic [OFF_W-1:0]  off_now;
  logic [PH_W-1:0]   cur_now;
  logic              hit_now;
  logic              last_now;
  logic              issue;
  logic              alloc;
  logic [PH_W-1:0]   issue_pp;

  function automatic cpu_pkg::addr_t phys(input logic [PH_W-1:0] pp,
                                          input logic [OFF_W-1:0] off);
    phys = cpu_pkg::addr_t'(pp) * cpu_pkg::addr_t'(cpu_pkg::PAGE_WORDS)
         + cpu_pkg::addr_t'(off);
  endfunction

  // the start cycle looks at page 0 directly
  assign req_now  = (state == S_IDLE) ? pkt : pkt_q;
  assign lp_now   = PG_W'(req_now.addr / cpu_pkg::PAGE_WORDS);
  assign off_now  = OFF_W'(req_now.addr % cpu_pkg::PAGE_WORDS);
  assign cur_now  = (state == S_IDLE) ? '0 : cur;
  assign hit_now  = (cur_now == '0) ? (lp_now == '0) : (log_pg[cur_now] == lp_now);
  assign last_now = (next_pg[cur_now] == cur_now);
  assign rdata    = mem_rdata;   // valid together with done

  always_comb begin
    issue    = 1'b0;
    alloc    = 1'b0;
    issue_pp = cur_now;
    case (state)
      S_IDLE: begin
        if (start && lp_now == last_lp) begin
          issue    = 1'b1;   // shortcut hit
          issue_pp = last_pp;
        end else if (start) begin
          issue = hit_now;
        end
      end
      S_WALK: issue = hit_now;
      S_SCAN: begin
        alloc    = (log_pg[scan] == '0);
        issue    = alloc;
        issue_pp = scan;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state   <= S_IDLE;
      mem_en  <= 1'b0;
      mem_we  <= 1'b0;
      done    <= 1'b0;
      last_lp <= '0;
      last_pp <= '0;
      cur     <= '0;
      scan    <= '0;
      for (int i = 0; i < NUM_PAGES; i++) begin
        next_pg[i] <= PH_W'(i);
        log_pg[i]  <= '0;
      end
      // boot chain 0 -> 5 -> 2 -> 1
      next_pg[0] <= PH_W'(5);
      next_pg[5] <= PH_W'(2);
      next_pg[2] <= PH_W'(1);
      log_pg[5]  <= PG_W'(2);
      log_pg[2]  <= PG_W'(3);
      log_pg[1]  <= PG_W'(1);
    end else begin
      mem_en <= issue;
      mem_we <= issue && req_now.we;
      done   <= mem_en;
      if (issue) begin
        last_lp <= lp_now;
        last_pp <= issue_pp;
      end
      if (alloc) begin
        next_pg[cur]  <= scan;   // append to the chain end
        next_pg[scan] <= scan;
        log_pg[scan]  <= lp_now;
      end
      if (issue) begin
        state <= S_IDLE;
      end else if (state == S_SCAN) begin
        scan <= scan + 1'b1;
      end else if (state == S_WALK || start) begin
        if (last_now) begin
          state <= S_SCAN;
          cur   <= cur_now;
          scan  <= PH_W'(1);
        end else begin
          state <= S_WALK;
          cur   <= next_pg[cur_now];
        end
      end
    end
  end

  always_ff @(posedge clka) begin
    if (start) pkt_q <= pkt;
    if (issue) begin
      mem_addr  <= phys(issue_pp, off_now);
      mem_wdata <= req_now.wdata;
    end
  end

endmodule
